/* common/mem_pkg.sv */
package mem_pkg;

    // one machine word and one byte address, both 32 bits on RV32I
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;

    // funct3 encodings of the load group
    // the store group reuses the first three with the same width meaning (sb, sh, sw)
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // data RAM geometry
    localparam int MEM_WORDS = 256;
    localparam int WORD_AW   = 8;

endpackage

/* common/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if
    import mem_pkg::*;
(
    input logic clk
);

    logic               we;
    logic [3:0]         byte_en;
    logic [WORD_AW-1:0] word_addr;
    data_t              wdata;
    data_t              rdata;

    // the load/store unit owns the request side of the port
    modport lsu (
        input  clk,
        output we,
        output byte_en,
        output word_addr,
        output wdata,
        input  rdata
    );

    // the RAM answers with the word one edge after word_addr is seen
    modport ram (
        input  clk,
        input  we,
        input  byte_en,
        input  word_addr,
        input  wdata,
        output rdata
    );

endinterface

/* lsu/store_align.sv */
`timescale 1ns/1ps

module store_align
    import mem_pkg::*;
(
    input  logic [2:0] funct3,
    input  logic [1:0] offset,
    input  data_t      store_data,
    output logic [3:0] byte_en,
    output data_t      lane_data,
    output logic       misaligned,
    output logic       illegal
);

    logic [4:0] shamt;
    data_t      byte_part;
    data_t      half_part;

    // bit shift that moves lane 0 up to the addressed lane
    assign shamt     = {offset, 3'b000};
    assign byte_part = {24'b0, store_data[7:0]};
    assign half_part = {16'b0, store_data[15:0]};

    always_comb begin
        byte_en    = 4'b0000;
        lane_data  = store_data;
        misaligned = 1'b0;
        illegal    = 1'b0;
        case (funct3)
            F3_LB: begin
                byte_en   = 4'b0001 << offset;
                lane_data = byte_part << shamt;
            end
            F3_LH: begin
                // a halfword starting in the top lane would cross into the next word
                if (offset == 2'd3) begin
                    misaligned = 1'b1;
                end else begin
                    byte_en   = 4'b0011 << offset;
                    lane_data = half_part << shamt;
                end
            end
            F3_LW: begin
                if (offset != 2'd0) begin
                    misaligned = 1'b1;
                end else begin
                    byte_en   = 4'b1111;
                    lane_data = store_data;
                end
            end
            default: begin
                // there is no unsigned store, so 100 and 101 land here too
                illegal = 1'b1;
            end
        endcase
    end

    // a store that passes both checks must touch at least one lane
    always_comb begin
        if (!misaligned && !illegal) begin
            assert (byte_en != 4'b0000)
                else $error("store_align: legal store with empty byte_en");
        end
    end

endmodule

/* lsu/load_extract.sv */
`timescale 1ns/1ps

module load_extract
    import mem_pkg::*;
(
    input  logic [2:0] funct3,
    input  logic [1:0] offset,
    input  data_t      word,
    output data_t      result
);

    logic [4:0]  shamt;
    data_t       shifted;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // bring the addressed lane down to bit 0, then cut out the field
    assign shamt    = {offset, 3'b000};
    assign shifted  = word >> shamt;
    assign sel_byte = shifted[7:0];
    assign sel_half = shifted[15:0];

    always_comb begin
        case (funct3)
            F3_LB: begin
                result = {{24{sel_byte[7]}}, sel_byte};
            end
            F3_LH: begin
                result = {{16{sel_half[15]}}, sel_half};
            end
            F3_LBU: begin
                result = {24'b0, sel_byte};
            end
            F3_LHU: begin
                result = {16'b0, sel_half};
            end
            default: begin
                // only LW reaches here, illegal codes never get a response
                result = word;
            end
        endcase
    end

endmodule

/* lsu/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  logic       req_write,
    input  logic [2:0] funct3,
    input  addr_t      addr,
    input  data_t      store_data,
    output logic       load_valid,
    output data_t      load_data,
    output logic       fault,
    mem_port_if.lsu    mem
);

    logic [1:0] offset;
    logic [3:0] st_byte_en;
    data_t      st_lane_data;
    logic       st_misaligned;
    logic       st_illegal;
    logic       ld_misaligned;
    logic       ld_illegal;
    logic       req_bad;
    logic       load_ok;
    logic       load_pending;
    logic       fault_q;
    logic [2:0] funct3_q;
    logic [1:0] offset_q;

    assign offset = addr[1:0];

    store_align u_store_align (
        .funct3     (funct3),
        .offset     (offset),
        .store_data (store_data),
        .byte_en    (st_byte_en),
        .lane_data  (st_lane_data),
        .misaligned (st_misaligned),
        .illegal    (st_illegal)
    );

    // load checks live here since store_align only knows the store encodings
    always_comb begin
        ld_misaligned = 1'b0;
        ld_illegal    = 1'b0;
        case (funct3)
            F3_LB, F3_LBU: ld_misaligned = 1'b0;
            F3_LH, F3_LHU: ld_misaligned = (offset == 2'd3);
            F3_LW:         ld_misaligned = (offset != 2'd0);
            default:       ld_illegal    = 1'b1;
        endcase
    end

    assign req_bad = req_write ? (st_misaligned | st_illegal)
                               : (ld_misaligned | ld_illegal);
    assign load_ok = req_valid & ~req_write & ~req_bad;

    // the write lands at the same edge that accepts the store
    assign mem.we        = req_valid & req_write & ~req_bad;
    assign mem.byte_en   = st_byte_en;
    assign mem.wdata     = st_lane_data;
    assign mem.word_addr = addr[WORD_AW+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_pending <= 1'b0;
            fault_q      <= 1'b0;
        end else begin
            load_pending <= load_ok;
            fault_q      <= req_valid & req_bad;
        end
    end

    // field selection travels with the load to the cycle where rdata shows up
    always_ff @(posedge clk) begin
        if (load_ok) begin
            funct3_q <= funct3;
            offset_q <= offset;
        end
    end

    load_extract u_load_extract (
        .funct3 (funct3_q),
        .offset (offset_q),
        .word   (mem.rdata),
        .result (load_data)
    );

    assign load_valid = load_pending;
    assign fault      = fault_q;

    // a request either answers with data or faults, never both
    assert property (@(posedge clk) disable iff (!arst_n) !(load_valid && fault))
        else $error("load_store_unit: load_valid and fault high together");

endmodule

/* hdl/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram
    import mem_pkg::*;
(
    input  logic    clk,
    mem_port_if.ram port
);

    data_t mem [MEM_WORDS];

    // each lane has its own enable so sb and sh leave the neighbours alone
    always_ff @(posedge clk) begin
        if (port.we) begin
            for (int i = 0; i < 4; i++) begin
                if (port.byte_en[i]) begin
                    mem[port.word_addr][8*i +: 8] <= port.wdata[8*i +: 8];
                end
            end
        end
    end

    // read every cycle, old contents on a same-edge write
    always_ff @(posedge clk) begin
        port.rdata <= mem[port.word_addr];
    end

    // a write strobe from the LSU always comes with defined lanes and address
    assert property (@(posedge clk)
        port.we |-> !$isunknown({port.byte_en, port.word_addr}))
        else $error("byte_ram: write with unknown byte_en or word_addr");

endmodule

/* hdl/data_mem_top.sv */
`timescale 1ns/1ps

module data_mem_top
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  logic       req_write,
    input  logic [2:0] funct3,
    input  addr_t      addr,
    input  data_t      store_data,
    output logic       load_valid,
    output data_t      load_data,
    output logic       fault
);

    mem_port_if u_mem_if (
        .clk (clk)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .funct3     (funct3),
        .addr       (addr),
        .store_data (store_data),
        .load_valid (load_valid),
        .load_data  (load_data),
        .fault      (fault),
        .mem        (u_mem_if.lsu)
    );

    byte_ram u_ram (
        .clk  (clk),
        .port (u_mem_if.ram)
    );

endmodule

/* testbench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input data_t got, input data_t exp);
    assert (got === exp)
        else begin
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
            error_count++;
        end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got === exp)
        else begin
            $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
            error_count++;
        end
endtask

// one request, then the response it should produce one cycle later
task automatic do_access(input logic write, input logic [2:0] f3,
                         input addr_t a, input data_t d);
    logic  bad;
    data_t exp_data;
    int    cycles;
    bad      = expect_fault(write, f3, a[1:0]);
    exp_data = model_load(f3, a);
    @(negedge clk);
    req_valid  = 1'b1;
    req_write  = write;
    funct3     = f3;
    addr       = a;
    store_data = d;
    @(negedge clk);
    req_valid = 1'b0;
    if (write && !bad) begin
        model_store(f3, a, d);
        check_flag("load_valid", load_valid, 1'b0);
        check_flag("fault", fault, 1'b0);
    end else begin
        cycles = 1;
        while (!load_valid && !fault && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!load_valid && !fault) begin
            $display("timeout at %0t: neither load_valid nor fault came within %0d cycles",
                     $time, WAIT_LIMIT);
            timeout_count++;
        end else begin
            assert (cycles == 1)
                else begin
                    $display("ERROR t=%0t response latency: got %0d expected 1", $time, cycles);
                    error_count++;
                end
            check_flag("fault", fault, bad);
            check_flag("load_valid", load_valid, !bad);
            if (!bad) begin
                check_value("load_data", load_data, exp_data);
            end
        end
    end
endtask

task automatic reset_and_check();
    for (int i = 0; i < RESET_CYCLES; i++) begin
        @(posedge clk);
        @(negedge clk);
        check_flag("load_valid", load_valid, 1'b0);
        check_flag("fault", fault, 1'b0);
    end
    arst_n = 1'b1;
    for (int i = 0; i < 3; i++) begin
        @(negedge clk);
        check_flag("load_valid", load_valid, 1'b0);
        check_flag("fault", fault, 1'b0);
    end
endtask

// the RAM powers up unknown, so every word gets a pattern tied to its index
task automatic fill_memory();
    data_t w;
    for (int i = 0; i < MEM_WORDS; i++) begin
        w = (32'(i) * 32'h0101_0101) ^ (32'(i) << 20) ^ 32'h5a3c_c3a5;
        do_access(1'b1, F3_LW, addr_t'(i * 4), w);
    end
endtask

task automatic test_word_store_load();
    addr_t a;
    for (int n = 0; n < 8; n++) begin
        a = addr_t'(32'($urandom_range(0, MEM_WORDS - 1)) << 2);
        do_access(1'b1, F3_LW, a, $urandom);
        do_access(1'b0, F3_LW, a, '0);
    end
endtask

task automatic test_byte_halfword_lanes();
    addr_t base;
    base = 32'h0000_0100;
    for (int off = 0; off < 4; off++) begin
        do_access(1'b1, F3_LB, base + addr_t'(off), $urandom);
        do_access(1'b0, F3_LW, base, '0);
        do_access(1'b0, F3_LBU, base + addr_t'(off), '0);
    end
    base = 32'h0000_0104;
    for (int off = 0; off < 3; off++) begin
        do_access(1'b1, F3_LH, base + addr_t'(off), $urandom);
        do_access(1'b0, F3_LW, base, '0);
        do_access(1'b0, F3_LW, base + 32'd4, '0);
    end
endtask

task automatic test_extension();
    addr_t base;
    data_t w;
    for (int n = 0; n < 8; n++) begin
        base = addr_t'((16 + n) * 4);
        w    = $urandom | 32'h8000_0000;
        // even rounds make every byte negative so each lane sees sign extension
        if (n % 2 == 0) begin
            w = w | 32'h8080_8080;
        end
        do_access(1'b1, F3_LW, base, w);
        for (int off = 0; off < 4; off++) begin
            do_access(1'b0, F3_LB, base + addr_t'(off), '0);
            do_access(1'b0, F3_LBU, base + addr_t'(off), '0);
        end
        for (int off = 0; off < 3; off++) begin
            do_access(1'b0, F3_LH, base + addr_t'(off), '0);
            do_access(1'b0, F3_LHU, base + addr_t'(off), '0);
        end
    end
endtask

task automatic test_faults();
    addr_t base;
    base = 32'h0000_0200;
    for (int off = 1; off < 4; off++) begin
        do_access(1'b0, F3_LW, base + addr_t'(off), '0);
        do_access(1'b1, F3_LW, base + addr_t'(off), $urandom);
        do_access(1'b0, F3_LW, base, '0);
    end
    do_access(1'b0, F3_LH, base + 32'd3, '0);
    do_access(1'b0, F3_LHU, base + 32'd3, '0);
    do_access(1'b1, F3_LH, base + 32'd3, $urandom);
    do_access(1'b0, 3'b011, base, '0);
    do_access(1'b1, 3'b011, base, $urandom);
    do_access(1'b0, 3'b110, base, '0);
    do_access(1'b1, F3_LBU, base, $urandom);
    do_access(1'b1, F3_LHU, base, $urandom);
    do_access(1'b0, F3_LW, base, '0);
endtask

task automatic random_legal_request(output logic write, output logic [2:0] f3,
                                    output addr_t a, output data_t d);
    logic [7:0] word_idx;
    logic [1:0] off;
    logic [2:0] codes [5];
    codes    = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
    write    = 1'($urandom_range(0, 1));
    f3       = write ? codes[$urandom_range(0, 2)] : codes[$urandom_range(0, 4)];
    // a small window of words keeps stores and loads colliding
    word_idx = 8'($urandom_range(0, 15));
    off      = 2'($urandom_range(0, 3));
    if (f3 == F3_LH || f3 == F3_LHU) begin
        off = 2'($urandom_range(0, 2));
    end else if (f3 == F3_LW) begin
        off = 2'd0;
    end
    a = {22'b0, word_idx, off};
    d = $urandom;
endtask

// one request per cycle, each response checked a cycle after it was sent
task automatic test_back_to_back();
    logic       exp_valid;
    data_t      exp_data;
    logic       write;
    logic [2:0] f3;
    addr_t      a;
    data_t      d;
    exp_valid = 1'b0;
    exp_data  = '0;
    @(negedge clk);
    for (int n = 0; n <= STREAM_LEN; n++) begin
        if (n > 0) begin
            check_flag("load_valid", load_valid, exp_valid);
            check_flag("fault", fault, 1'b0);
            if (exp_valid) begin
                check_value("load_data", load_data, exp_data);
            end
        end
        if (n < STREAM_LEN) begin
            random_legal_request(write, f3, a, d);
            req_valid  = 1'b1;
            req_write  = write;
            funct3     = f3;
            addr       = a;
            store_data = d;
            exp_valid  = !write;
            if (write) begin
                model_store(f3, a, d);
            end else begin
                exp_data = model_load(f3, a);
            end
        end else begin
            req_valid = 1'b0;
        end
        @(negedge clk);
    end
endtask

`endif

/* testbench/tb_data_mem.sv */
`timescale 1ns/1ps

module tb_data_mem
    import mem_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int WAIT_LIMIT   = 20;
    localparam int STREAM_LEN   = 200;
    localparam int MEM_BYTES    = MEM_WORDS * 4;

    logic       clk;
    logic       arst_n;
    logic       req_valid;
    logic       req_write;
    logic [2:0] funct3;
    addr_t      addr;
    data_t      store_data;
    logic       load_valid;
    data_t      load_data;
    logic       fault;

    // byte-wide reference memory, little endian like the RAM behind the DUT
    logic [7:0] model_mem [MEM_BYTES];

    int          error_count;
    int          timeout_count;

    data_mem_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .funct3     (funct3),
        .addr       (addr),
        .store_data (store_data),
        .load_valid (load_valid),
        .load_data  (load_data),
        .fault      (fault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // a request faults when its width does not fit the offset or its code is unknown
    function automatic logic expect_fault(input logic write, input logic [2:0] f3,
                                          input logic [1:0] offset);
        logic bad;
        case (f3)
            F3_LB:   bad = 1'b0;
            F3_LH:   bad = (offset == 2'd3);
            F3_LW:   bad = (offset != 2'd0);
            F3_LBU:  bad = write;
            F3_LHU:  bad = write || (offset == 2'd3);
            default: bad = 1'b1;
        endcase
        return bad;
    endfunction

    function automatic void model_store(input logic [2:0] f3, input addr_t a, input data_t d);
        int idx;
        idx = int'(a[9:0]);
        model_mem[idx] = d[7:0];
        if (f3 == F3_LH || f3 == F3_LW) begin
            model_mem[(idx + 1) % MEM_BYTES] = d[15:8];
        end
        if (f3 == F3_LW) begin
            model_mem[(idx + 2) % MEM_BYTES] = d[23:16];
            model_mem[(idx + 3) % MEM_BYTES] = d[31:24];
        end
    endfunction

    function automatic data_t model_load(input logic [2:0] f3, input addr_t a);
        int         idx;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        data_t      result;
        idx = int'(a[9:0]);
        b0  = model_mem[idx];
        b1  = model_mem[(idx + 1) % MEM_BYTES];
        b2  = model_mem[(idx + 2) % MEM_BYTES];
        b3  = model_mem[(idx + 3) % MEM_BYTES];
        case (f3)
            F3_LB:   result = {{24{b0[7]}}, b0};
            F3_LBU:  result = {24'b0, b0};
            F3_LH:   result = {{16{b1[7]}}, b1, b0};
            F3_LHU:  result = {16'b0, b1, b0};
            default: result = {b3, b2, b1, b0};
        endcase
        return result;
    endfunction

    `include "tb_tasks.svh"

    initial begin
        arst_n        = 1'b0;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        funct3        = 3'b000;
        addr          = '0;
        store_data    = '0;
        error_count   = 0;
        timeout_count = 0;
        void'($urandom(32'h68aad612));

        reset_and_check();
        fill_memory();
        test_word_store_load();
        test_byte_halfword_lanes();
        test_extension();
        test_faults();
        test_back_to_back();

        $display("checks done: %0d value errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* data_mem.f */
+incdir+testbench
common/mem_pkg.sv
common/mem_port_if.sv
lsu/store_align.sv
lsu/load_extract.sv
lsu/load_store_unit.sv
hdl/byte_ram.sv
hdl/data_mem_top.sv
testbench/tb_data_mem.sv

/* Makefile */
# Verilator build and run for the data memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_data_mem
FILELIST  ?= data_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard testbench/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
